// File: compile.f
+incdir+include
verilog/pixel_pkg.sv
verilog/line_ctrl_pkg.sv
verilog/line_sram.sv
verilog/line_store.sv
verilog/window_sequencer.sv
verilog/window_shifter.sv
verilog/line_window_top.sv
dv/line_window_tb.sv

// File: Makefile
# Verilator build and run of the line window testbench

VERILATOR ?= verilator
TOP       ?= line_window_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source, a header or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# exit status of the simulator is the test result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

// File: dv/line_window_tb.sv
// line window testbench with a test table, LFSR gaps, window model, checks and timeout
`timescale 1ns/1ps
`default_nettype none

`include "line_window_settings.svh"

module line_window_tb
    import pixel_pkg::*;
();

    localparam int W             = `IMG_WIDTH;
    localparam int H             = `IMG_HEIGHT;
    localparam int WIN           = `WIN_SIZE;
    localparam int CB            = `COLOR_BITS;
    localparam int NUM_TESTS     = 5;
    localparam int FRAME_PIXELS  = W * H;
    localparam int FRAME_WINDOWS = (H - WIN + 1) * (W - WIN + 1);
    localparam int CYCLE_LIMIT   = 10 * NUM_TESTS * (FRAME_PIXELS + FRAME_WINDOWS);

    typedef logic [$bits(window_t)-1:0] word_t;

    logic    clk = 1'b0;
    logic    rst_n;
    pixel_t  pix;
    logic    pix_valid;
    logic    pix_ready;
    window_t window;
    logic    window_valid;
    logic    window_ready;

    // test table, a gap value is the chance of a low cycle in quarters
    string         test_name  [NUM_TESTS];
    logic [CB-1:0] test_tag   [NUM_TESTS];
    logic [1:0]    valid_gaps [NUM_TESTS];
    logic [1:0]    ready_gaps [NUM_TESTS];

    logic [31:0] lfsr_state;
    int          cycle_count = 0;

    line_window_top line_window_top_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .pix          (pix),
        .pix_valid    (pix_valid),
        .pix_ready    (pix_ready),
        .window       (window),
        .window_valid (window_valid),
        .window_ready (window_ready)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: frames did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Test failed");
            $fatal(1, "simulation timeout");
        end
    end

    // taps 32, 22, 2, 1
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [1:0] random_quarter();
        logic [1:0] q;
        q[0] = lfsr_step();
        q[1] = lfsr_step();
        return q;
    endfunction

    function automatic pixel_t make_pixel(input logic [CB-1:0] tag, input int row, input int col);
        pixel_t p;
        p.red   = tag;
        p.green = CB'(row);
        p.blue  = CB'(col);
        return p;
    endfunction

    // element (i, j) is row r-3+j, column c-3+i
    function automatic window_t model_window(input logic [CB-1:0] tag, input int r, input int c);
        window_t w;
        for (int i = 0; i < WIN; i++) begin
            for (int j = 0; j < WIN; j++) begin
                w[i][j] = make_pixel(tag, r - WIN + 1 + j, c - WIN + 1 + i);
            end
        end
        return w;
    endfunction

    task automatic check_value(input string label, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            $display("FAIL %s: expected %h actual %h", label, expected, actual);
            $display("Test failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic set_entry(input int idx, input string name, input logic [CB-1:0] tag,
                             input logic [1:0] vgap, input logic [1:0] rgap);
        test_name[idx]  = name;
        test_tag[idx]   = tag;
        valid_gaps[idx] = vgap;
        ready_gaps[idx] = rgap;
    endtask

    // one frame in, all its windows out, both sides driven on the falling edge
    task automatic run_test(input int t);
        int      sent;
        int      got;
        int      r;
        int      c;
        logic    taken;
        logic    held;
        window_t held_window;
        string   name;
        sent  = 0;
        got   = 0;
        taken = 1'b0;
        held  = 1'b0;
        name  = test_name[t];
        $display("running %s", name);
        while (sent < FRAME_PIXELS || got < FRAME_WINDOWS) begin
            @(negedge clk);
            if (held) begin
                check_value($sformatf("%s hold valid", name), word_t'(1'b1),
                            word_t'(window_valid));
                check_value($sformatf("%s hold data", name), word_t'(held_window),
                            word_t'(window));
            end
            if (taken) begin
                pix_valid = 1'b0;
            end
            taken = 1'b0;
            if (sent < FRAME_PIXELS && !pix_valid && random_quarter() >= valid_gaps[t]) begin
                pix       = make_pixel(test_tag[t], sent / W, sent % W);
                pix_valid = 1'b1;
            end
            // a pixel offered now moves at the coming rising edge
            if (pix_valid && pix_ready) begin
                taken = 1'b1;
                sent++;
            end
            window_ready = (random_quarter() >= ready_gaps[t]);
            held         = window_valid && !window_ready;
            held_window  = window;
            if (window_valid && window_ready) begin
                r = WIN - 1 + got / (W - WIN + 1);
                c = WIN - 1 + got % (W - WIN + 1);
                check_value($sformatf("%s window r%0d c%0d", name, r, c),
                            word_t'(model_window(test_tag[t], r, c)), word_t'(window));
                got++;
            end
        end
        @(negedge clk);
        pix_valid = 1'b0;
        // nothing left over, and the input side is open again
        check_value($sformatf("%s extra window", name), word_t'(1'b0), word_t'(window_valid));
        check_value($sformatf("%s pix_ready after frame", name), word_t'(1'b1),
                    word_t'(pix_ready));
    endtask

    initial begin
        rst_n        = 1'b0;
        pix          = '0;
        pix_valid    = 1'b0;
        window_ready = 1'b0;
        lfsr_state   = 32'h8da0;

        set_entry(0, "full_rate",    8'h11, 2'd0, 2'd0);
        set_entry(1, "ready_stalls", 8'h22, 2'd0, 2'd2);
        set_entry(2, "valid_gaps",   8'h33, 2'd2, 2'd0);
        set_entry(3, "both_random",  8'h44, 2'd3, 2'd3);
        set_entry(4, "back_to_back", 8'h55, 2'd0, 2'd1);

        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_value("reset pix_ready", word_t'(1'b1), word_t'(pix_ready));
        check_value("reset window_valid", word_t'(1'b0), word_t'(window_valid));

        // frames follow each other without a reset in between
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end

        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/line_window_top.sv
// line window top level connecting sequencer, line store and window shifter
`timescale 1ns/1ps
`default_nettype none

module line_window_top
    import pixel_pkg::*, line_ctrl_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  pixel_t  pix,
    input  logic    pix_valid,
    output logic    pix_ready,
    output window_t window,
    output logic    window_valid,
    input  logic    window_ready
);

    logic          wr_en;
    col_idx_t      wr_col;
    logic          rd_en;
    col_idx_t      rd_col;
    bank_idx_t     fill_bank;
    logic          shift_en;
    pixel_column_t read_col;

    window_sequencer window_sequencer_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .pix_valid    (pix_valid),
        .pix_ready    (pix_ready),
        .window_ready (window_ready),
        .window_valid (window_valid),
        .wr_en        (wr_en),
        .wr_col       (wr_col),
        .rd_en        (rd_en),
        .rd_col       (rd_col),
        .fill_bank    (fill_bank),
        .shift_en     (shift_en)
    );

    line_store line_store_inst (
        .clk       (clk),
        .wr_en     (wr_en),
        .wr_col    (wr_col),
        .pix       (pix),
        .rd_en     (rd_en),
        .rd_col    (rd_col),
        .fill_bank (fill_bank),
        .read_col  (read_col)
    );

    window_shifter window_shifter_inst (
        .clk      (clk),
        .shift_en (shift_en),
        .read_col (read_col),
        .window   (window)
    );

endmodule

`default_nettype wire

// File: verilog/window_shifter.sv
// 4x4 window shift register loaded one pixel column at a time
`timescale 1ns/1ps
`default_nettype none

`include "line_window_settings.svh"

module window_shifter
    import pixel_pkg::*;
(
    input  logic          clk,
    input  logic          shift_en,
    input  pixel_column_t read_col,
    output window_t       window
);

    // columns move one place left, the fresh column enters on the right
    always_ff @(posedge clk) begin
        if (shift_en) begin
            for (int i = 0; i < `WIN_SIZE - 1; i++) begin
                window[i] <= window[i + 1];
            end
            window[`WIN_SIZE - 1] <= read_col;
        end
    end

endmodule

`default_nettype wire

// File: verilog/window_sequencer.sv
// fill and emit counters, bank rotation, pixel and window handshakes, read and shift strobes
`timescale 1ns/1ps
`default_nettype none

`include "line_window_settings.svh"

module window_sequencer
    import line_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      pix_valid,
    output logic      pix_ready,
    input  logic      window_ready,
    output logic      window_valid,
    output logic      wr_en,
    output col_idx_t  wr_col,
    output logic      rd_en,
    output col_idx_t  rd_col,
    output bank_idx_t fill_bank,
    output logic      shift_en
);

    localparam col_idx_t  LAST_COL       = col_idx_t'(`IMG_WIDTH - 1);
    localparam col_idx_t  FIRST_WIN_COL  = col_idx_t'(`WIN_SIZE - 1);
    localparam row_idx_t  LAST_ROW       = row_idx_t'(`IMG_HEIGHT - 1);
    localparam row_idx_t  FIRST_EMIT_ROW = row_idx_t'(`WIN_SIZE - 1);
    localparam bank_idx_t LAST_BANK      = bank_idx_t'(`NUM_BANKS - 1);

    // fill side
    col_idx_t fill_col;
    row_idx_t fill_row;
    logic     fill_done;

    // emit side, emit_row is the next row that gets a window pass
    col_idx_t emit_col;
    row_idx_t emit_row;
    logic     emit_busy;

    // column read from the RAMs and not yet shifted into the window
    logic     col_pending;
    col_idx_t shift_col;

    logic pix_fire;
    logic fill_end;
    logic emit_finish;
    logic advance;
    logic start_emit;
    logic slot_free;

    assign pix_ready = !fill_done;
    assign pix_fire  = pix_valid && pix_ready;
    assign wr_en     = pix_fire;
    assign wr_col    = fill_col;

    // shifting destroys the current window, so it must be empty or leaving
    assign slot_free = !window_valid || window_ready;
    assign shift_en  = col_pending && slot_free;
    assign rd_en     = emit_busy && (!col_pending || shift_en);
    assign rd_col    = emit_col;

    assign emit_finish = rd_en && (emit_col == LAST_COL);
    assign fill_end    = fill_done || (pix_fire && (fill_col == LAST_COL));

    // rotate only once the spare row is full and the last column read is out
    assign advance    = fill_end && (!emit_busy || emit_finish);
    assign start_emit = advance && (fill_row == emit_row);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fill_col  <= '0;
            fill_row  <= '0;
            fill_bank <= '0;
            fill_done <= 1'b0;
        end else begin
            if (pix_fire) begin
                fill_col <= (fill_col == LAST_COL) ? '0 : fill_col + 1'b1;
            end
            if (advance) begin
                fill_done <= 1'b0;
                fill_row  <= (fill_row == LAST_ROW) ? '0 : fill_row + 1'b1;
                fill_bank <= (fill_bank == LAST_BANK) ? '0 : fill_bank + 1'b1;
            end else if (fill_end) begin
                // hold the source off until the emission catches up
                fill_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            emit_col  <= '0;
            emit_row  <= FIRST_EMIT_ROW;
            emit_busy <= 1'b0;
        end else begin
            if (start_emit) begin
                emit_busy <= 1'b1;
                emit_row  <= (emit_row == LAST_ROW) ? FIRST_EMIT_ROW : emit_row + 1'b1;
            end else if (emit_finish) begin
                emit_busy <= 1'b0;
            end
            if (rd_en) begin
                emit_col <= (emit_col == LAST_COL) ? '0 : emit_col + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col_pending  <= 1'b0;
            window_valid <= 1'b0;
        end else begin
            if (rd_en) begin
                col_pending <= 1'b1;
            end else if (shift_en) begin
                col_pending <= 1'b0;
            end
            // first three columns of a row only prime the window
            if (shift_en) begin
                window_valid <= (shift_col >= FIRST_WIN_COL);
            end else if (window_ready) begin
                window_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            shift_col <= emit_col;
        end
    end

    a_bank_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        fill_bank < bank_idx_t'(`NUM_BANKS)
    ) else $error("window_sequencer: fill_bank out of range");

    a_window_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        window_valid && !window_ready |=> window_valid
    ) else $error("window_sequencer: window dropped before it was taken");

endmodule

`default_nettype wire

// File: verilog/line_store.sv
// five rotating line RAMs with write steering and an age-ordered read column
`timescale 1ns/1ps
`default_nettype none

`include "line_window_settings.svh"

module line_store
    import pixel_pkg::*, line_ctrl_pkg::*;
(
    input  logic          clk,
    input  logic          wr_en,
    input  col_idx_t      wr_col,
    input  pixel_t        pix,
    input  logic          rd_en,
    input  col_idx_t      rd_col,
    input  bank_idx_t     fill_bank,
    output pixel_column_t read_col
);

    pixel_t    bank_rdata [`NUM_BANKS];
    bank_idx_t rd_bank;

    // the fill bank takes the write, the other four serve the read
    for (genvar b = 0; b < `NUM_BANKS; b++) begin : g_bank
        logic is_fill;

        assign is_fill = (fill_bank == bank_idx_t'(b));

        line_sram line_sram_inst (
            .clk   (clk),
            .wr_en (wr_en && is_fill),
            .rd_en (rd_en && !is_fill),
            .addr  (is_fill ? wr_col : rd_col),
            .wdata (pix),
            .rdata (bank_rdata[b])
        );
    end

    // fill bank at read time, the rotation may move on before the shift
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_bank <= fill_bank;
        end
    end

    // oldest row sits in the bank right after the fill bank, then ascending
    always_comb begin
        bank_idx_t sel;
        for (int k = 0; k < `WIN_SIZE; k++) begin
            sel = bank_idx_t'((int'(rd_bank) + 1 + k) % `NUM_BANKS);
            read_col[k] = bank_rdata[sel];
        end
    end

endmodule

`default_nettype wire

// File: verilog/line_sram.sv
// single-port line RAM with a one-cycle registered read that holds its value
`timescale 1ns/1ps
`default_nettype none

`include "line_window_settings.svh"

module line_sram
    import pixel_pkg::*, line_ctrl_pkg::*;
(
    input  logic     clk,
    input  logic     wr_en,
    input  logic     rd_en,
    input  col_idx_t addr,
    input  pixel_t   wdata,
    output pixel_t   rdata
);

    // one image row
    pixel_t mem [`IMG_WIDTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[addr] <= wdata;
        end
    end

    // output register only moves on a read, so the column can wait downstream
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rdata <= mem[addr];
        end
    end

    // the bank being filled must never be one of the banks read for the window
    a_single_port: assert property (
        @(posedge clk) !(wr_en && rd_en)
    ) else $error("line_sram: read and write in the same cycle");

endmodule

`default_nettype wire

// File: verilog/line_ctrl_pkg.sv
// bank, column and row index types for the line RAM control
`default_nettype none

package line_ctrl_pkg;

    `include "line_window_settings.svh"

    localparam int BANK_BITS = $clog2(`NUM_BANKS);
    localparam int COL_BITS  = $clog2(`IMG_WIDTH);
    localparam int ROW_BITS  = $clog2(`IMG_HEIGHT);

    // which of the rotating line RAMs
    typedef logic [BANK_BITS-1:0] bank_idx_t;

    // pixel address inside one line RAM
    typedef logic [COL_BITS-1:0] col_idx_t;

    // row number inside the frame
    typedef logic [ROW_BITS-1:0] row_idx_t;

endpackage

`default_nettype wire

// File: verilog/pixel_pkg.sv
// pixel, pixel column and 4x4 window types
`default_nettype none

package pixel_pkg;

    `include "line_window_settings.svh"

    // one RGB sample as it arrives from the source
    typedef struct packed {
        logic [`COLOR_BITS-1:0] red;
        logic [`COLOR_BITS-1:0] green;
        logic [`COLOR_BITS-1:0] blue;
    } pixel_t;

    // vertical slice of the window
    // element 0 holds the oldest row, element WIN_SIZE-1 the newest
    typedef pixel_t [`WIN_SIZE-1:0] pixel_column_t;

    // full window handed to the interpolator
    // element 0 is the leftmost column, element WIN_SIZE-1 the rightmost
    // so window[i][j] is column c-3+i of row r-3+j
    typedef pixel_column_t [`WIN_SIZE-1:0] window_t;

endpackage

`default_nettype wire

// File: include/line_window_settings.svh
// image size, color depth, window edge and line RAM count macros
`ifndef LINE_WINDOW_SETTINGS_SVH
`define LINE_WINDOW_SETTINGS_SVH

// frame geometry, small for simulation
`define IMG_WIDTH  8
`define IMG_HEIGHT 6

// bits per red, green and blue channel
`define COLOR_BITS 8

// edge of the square interpolation window
`define WIN_SIZE   4

// one spare RAM beyond the window height, so a row can fill during emission
`define NUM_BANKS  5

`endif
